/* hdl/ifetch_settings.svh */
////////////////////////////////////////
// Build-time sizes for the fetch front end
// Included by the package and by every RTL
// file that sizes an array or a counter
////////////////////////////////////////

`ifndef IFETCH_SETTINGS_SVH
`define IFETCH_SETTINGS_SVH

// Hardware threads sharing the fetch pipeline
`define IFETCH_THREADS 4

// Direct-mapped instruction cache geometry
`define L1I_SETS 16
`define L1I_LINE_WORDS 4

// Start address of thread 0
`define RESET_PC 32'h0

// Thread n starts at RESET_PC + n * stride
`define THREAD_PC_STRIDE 32'h100

`endif

/* hdl/ifetch_pkg.sv */
////////////////////////////////////////
// Shared types of the fetch front end
// Referenced with scoped names, never imported
////////////////////////////////////////

`include "ifetch_settings.svh"

package ifetch_pkg;

	// Address or instruction word
	typedef logic [31:0] scalar_t;

	// Thread number and one-bit-per-thread masks
	typedef logic [$clog2(`IFETCH_THREADS)-1:0] thread_idx_t;
	typedef logic [`IFETCH_THREADS-1:0] thread_bitmap_t;

	// Address split: tag | set | word | 2'b00
	typedef logic [$clog2(`L1I_SETS)-1:0] l1i_set_idx_t;
	typedef logic [$clog2(`L1I_LINE_WORDS)-1:0] l1i_word_idx_t;
	typedef logic [29-$clog2(`L1I_SETS)-$clog2(`L1I_LINE_WORDS):0] l1i_tag_t;

	// Line fill sequencer
	typedef enum logic [1:0]
	{
		fill_idle,
		fill_request,
		fill_finish
	} fill_state_t;

endpackage

/* hdl/l1i_fill_if.sv */
////////////////////////////////////////
// Cache array write port of the fill machine
// fsm side drives, both pipeline stages listen
////////////////////////////////////////

`timescale 1ns/1ps

interface l1i_fill_if;

	// Tag write, also marks the line valid
	logic tag_update_en;
	ifetch_pkg::l1i_set_idx_t set;
	ifetch_pkg::l1i_tag_t tag;

	// One instruction word per beat, same set as above
	logic data_update_en;
	ifetch_pkg::l1i_word_idx_t word;
	ifetch_pkg::scalar_t data;

	modport fsm(output tag_update_en, set, tag, data_update_en, word, data);
	modport cache(input tag_update_en, set, tag, data_update_en, word, data);

endinterface

/* hdl/fill_beat_counter.sv */
////////////////////////////////////////
// Word counter for one line fill
// Gives the beat offset, flags the final word
////////////////////////////////////////

`timescale 1ns/1ps
`include "ifetch_settings.svh"

module fill_beat_counter(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      start,
	input  logic                      advance,
	output ifetch_pkg::l1i_word_idx_t word,
	output logic                      last);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			word <= '0;
		else if (start)
			word <= '0;
		else if (advance)
			word <= word + 1'b1;
	end

	assign last = word == ifetch_pkg::l1i_word_idx_t'(`L1I_LINE_WORDS - 1);

endmodule

/* hdl/ifetch_tag_stage.sv */
////////////////////////////////////////
// Fetch stage 1: picks a thread round-robin,
// keeps all program counters and the wait mask,
// reads tag and valid at the selected set
////////////////////////////////////////

`timescale 1ns/1ps
`include "ifetch_settings.svh"

module ifetch_tag_stage(
	input  logic                       clk,
	input  logic                       reset,
	input  ifetch_pkg::thread_bitmap_t fetch_en,
	l1i_fill_if.cache                  fill,
	input  logic                       miss_en,
	input  ifetch_pkg::thread_idx_t    miss_thread,
	input  ifetch_pkg::thread_bitmap_t wake_bitmap,
	output logic                       fetch_valid,
	output ifetch_pkg::scalar_t        fetch_pc,
	output ifetch_pkg::thread_idx_t    fetch_thread,
	output ifetch_pkg::l1i_tag_t       line_tag,
	output logic                       line_valid);

	localparam int SET_SHIFT = 2 + $bits(ifetch_pkg::l1i_word_idx_t);

	ifetch_pkg::scalar_t pc[`IFETCH_THREADS];
	ifetch_pkg::l1i_tag_t tag_array[`L1I_SETS];
	logic [`L1I_SETS-1:0] valid_bits;
	ifetch_pkg::thread_bitmap_t wait_bits;
	ifetch_pkg::thread_bitmap_t busy_bits;
	ifetch_pkg::thread_bitmap_t request;
	ifetch_pkg::thread_bitmap_t miss_oh;
	ifetch_pkg::thread_idx_t last_grant;
	ifetch_pkg::thread_idx_t sel_thread;
	ifetch_pkg::scalar_t sel_pc;
	ifetch_pkg::l1i_set_idx_t sel_set;
	logic sel_found;
	logic fetch_go;
	logic fill_tag_hit;

	// Thread fetched last cycle sits out one cycle
	// so a miss report never finds two of its fetches in flight
	assign request = fetch_en & ~wait_bits & ~busy_bits;

	// Round-robin search, starting after the last grant
	always_comb
	begin
		ifetch_pkg::thread_idx_t cand;
		sel_found = 1'b0;
		sel_thread = last_grant;
		for (int i = 1; i <= `IFETCH_THREADS; i++)
		begin
			cand = ifetch_pkg::thread_idx_t'((int'(last_grant) + i) % `IFETCH_THREADS);
			if (!sel_found && request[cand])
			begin
				sel_found = 1'b1;
				sel_thread = cand;
			end
		end
	end

	assign miss_oh = miss_en ? ifetch_pkg::thread_bitmap_t'(1) << miss_thread : '0;

	// Thread being rewound this cycle gets no fetch
	assign fetch_go = sel_found && !(miss_en && miss_thread == sel_thread);

	assign sel_pc = pc[sel_thread];
	assign sel_set = ifetch_pkg::l1i_set_idx_t'(sel_pc >> SET_SHIFT);
	assign fill_tag_hit = fill.tag_update_en && fill.set == sel_set;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int t = 0; t < `IFETCH_THREADS; t++)
				pc[t] <= ifetch_pkg::scalar_t'(`RESET_PC + t * `THREAD_PC_STRIDE);
			valid_bits <= '0;
			wait_bits <= '0;
			busy_bits <= '0;
			last_grant <= '0;
			fetch_valid <= 1'b0;
		end
		else
		begin
			// Miss rewinds the one fetch that went past the missing word
			for (int t = 0; t < `IFETCH_THREADS; t++)
			begin
				if (miss_oh[t])
					pc[t] <= pc[t] - 32'd4;
				else if (fetch_go && sel_thread == ifetch_pkg::thread_idx_t'(t))
					pc[t] <= pc[t] + 32'd4;
			end
			wait_bits <= (wait_bits | miss_oh) & ~wake_bitmap;
			busy_bits <= fetch_go ? ifetch_pkg::thread_bitmap_t'(1) << sel_thread : '0;
			if (sel_found)
				last_grant <= sel_thread;
			fetch_valid <= fetch_go;

			// Line goes invalid on its first refill word, valid again with the tag
			if (fill.data_update_en)
				valid_bits[fill.set] <= 1'b0;
			if (fill.tag_update_en)
				valid_bits[fill.set] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (fill.tag_update_en)
			tag_array[fill.set] <= fill.tag;
		fetch_pc <= sel_pc;
		fetch_thread <= sel_thread;

		// Bypass a same-cycle write to the selected set
		line_tag <= fill_tag_hit ? fill.tag : tag_array[sel_set];
		if (fill_tag_hit)
			line_valid <= 1'b1;
		else if (fill.data_update_en && fill.set == sel_set)
			line_valid <= 1'b0;
		else
			line_valid <= valid_bits[sel_set];
	end

endmodule

/* hdl/ifetch_data_stage.sv */
////////////////////////////////////////
// Fetch stage 2: tag compare and data read,
// registers either the instruction or a miss
////////////////////////////////////////

`timescale 1ns/1ps
`include "ifetch_settings.svh"

module ifetch_data_stage(
	input  logic                    clk,
	input  logic                    reset,
	l1i_fill_if.cache               fill,
	input  logic                    fetch_valid,
	input  ifetch_pkg::scalar_t     fetch_pc,
	input  ifetch_pkg::thread_idx_t fetch_thread,
	input  ifetch_pkg::l1i_tag_t    line_tag,
	input  logic                    line_valid,
	output logic                    instr_valid,
	output ifetch_pkg::scalar_t     instr,
	output ifetch_pkg::scalar_t     instr_pc,
	output ifetch_pkg::thread_idx_t instr_thread,
	output logic                    miss_en,
	output ifetch_pkg::thread_idx_t miss_thread,
	output ifetch_pkg::scalar_t     miss_addr);

	localparam int SET_SHIFT = 2 + $bits(ifetch_pkg::l1i_word_idx_t);
	localparam int TAG_SHIFT = SET_SHIFT + $bits(ifetch_pkg::l1i_set_idx_t);

	// Indexed by {set, word}
	ifetch_pkg::scalar_t data_array[`L1I_SETS * `L1I_LINE_WORDS];
	ifetch_pkg::l1i_set_idx_t pc_set;
	ifetch_pkg::l1i_word_idx_t pc_word;
	ifetch_pkg::l1i_tag_t pc_tag;
	logic hit;
	logic drop;

	assign pc_word = ifetch_pkg::l1i_word_idx_t'(fetch_pc >> 2);
	assign pc_set = ifetch_pkg::l1i_set_idx_t'(fetch_pc >> SET_SHIFT);
	assign pc_tag = ifetch_pkg::l1i_tag_t'(fetch_pc >> TAG_SHIFT);

	// Second term catches the tag write landing this very cycle
	assign hit = (line_valid && line_tag == pc_tag)
		|| (fill.tag_update_en && fill.set == pc_set && fill.tag == pc_tag);

	// Fetch of a thread that is being rewound right now is stale
	assign drop = miss_en && miss_thread == fetch_thread;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			instr_valid <= 1'b0;
			miss_en <= 1'b0;
		end
		else
		begin
			instr_valid <= fetch_valid && hit && !drop;
			miss_en <= fetch_valid && !hit && !drop;
		end
	end

	always_ff @(posedge clk)
	begin
		if (fill.data_update_en)
			data_array[{fill.set, fill.word}] <= fill.data;
		instr <= data_array[{pc_set, pc_word}];
		instr_pc <= fetch_pc;
		instr_thread <= fetch_thread;
		miss_thread <= fetch_thread;
		miss_addr <= fetch_pc;
	end

endmodule

/* hdl/l1i_fill_fsm.sv */
////////////////////////////////////////
// Miss queue and line fill over Wishbone classic
// One pending address per thread, lowest first;
// wakes every sleeper on the filled line
////////////////////////////////////////

`timescale 1ns/1ps
`include "ifetch_settings.svh"

module l1i_fill_fsm(
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       miss_en,
	input  ifetch_pkg::thread_idx_t    miss_thread,
	input  ifetch_pkg::scalar_t        miss_addr,
	l1i_fill_if.fsm                    fill,
	output ifetch_pkg::thread_bitmap_t wake_bitmap,
	output logic                       wb_cyc,
	output logic                       wb_stb,
	output ifetch_pkg::scalar_t        wb_adr,
	input  ifetch_pkg::scalar_t        wb_rdata,
	input  logic                       wb_ack);

	localparam int LINE_SHIFT = 2 + $bits(ifetch_pkg::l1i_word_idx_t);
	localparam int TAG_SHIFT = LINE_SHIFT + $bits(ifetch_pkg::l1i_set_idx_t);

	ifetch_pkg::fill_state_t state;
	ifetch_pkg::thread_bitmap_t pending;
	ifetch_pkg::scalar_t pending_addr[`IFETCH_THREADS];
	ifetch_pkg::scalar_t fill_line;
	ifetch_pkg::thread_bitmap_t miss_oh;
	ifetch_pkg::thread_bitmap_t wake_next;
	ifetch_pkg::thread_idx_t pick;
	ifetch_pkg::l1i_word_idx_t beat_word;
	logic beat_last;
	logic start;
	logic beat_done;

	assign start = state == ifetch_pkg::fill_idle && |pending;
	assign beat_done = state == ifetch_pkg::fill_request && wb_cyc && wb_ack;

	fill_beat_counter beat_counter(
		.clk(clk),
		.reset(reset),
		.start(start),
		.advance(beat_done),
		.word(beat_word),
		.last(beat_last));

	// Lowest pending thread wins
	always_comb
	begin
		pick = '0;
		for (int t = `IFETCH_THREADS - 1; t >= 0; t--)
			if (pending[t])
				pick = ifetch_pkg::thread_idx_t'(t);
	end

	assign miss_oh = miss_en ? ifetch_pkg::thread_bitmap_t'(1) << miss_thread : '0;

	// Includes a miss on this line reported during the tag write
	always_comb
	begin
		wake_next = '0;
		if (state == ifetch_pkg::fill_finish)
			for (int t = 0; t < `IFETCH_THREADS; t++)
				wake_next[t] = (pending[t]
					&& (pending_addr[t] >> LINE_SHIFT) == (fill_line >> LINE_SHIFT))
					|| (miss_oh[t] && (miss_addr >> LINE_SHIFT) == (fill_line >> LINE_SHIFT));
	end

	// Single-word classic cycles, address steady while cyc is high
	assign wb_stb = wb_cyc;
	assign wb_adr = {fill_line[31:LINE_SHIFT], beat_word, 2'b00};

	assign fill.data_update_en = beat_done;
	assign fill.word = beat_word;
	assign fill.data = wb_rdata;
	assign fill.set = ifetch_pkg::l1i_set_idx_t'(fill_line >> LINE_SHIFT);
	assign fill.tag = ifetch_pkg::l1i_tag_t'(fill_line >> TAG_SHIFT);
	assign fill.tag_update_en = state == ifetch_pkg::fill_finish;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= ifetch_pkg::fill_idle;
			pending <= '0;
			wake_bitmap <= '0;
			wb_cyc <= 1'b0;
		end
		else
		begin
			pending <= (pending | miss_oh) & ~wake_next;
			wake_bitmap <= wake_next;
			case (state)
				ifetch_pkg::fill_idle:
				begin
					if (start)
					begin
						state <= ifetch_pkg::fill_request;
						wb_cyc <= 1'b1;
					end
				end
				ifetch_pkg::fill_request:
				begin
					// Drop for one cycle after every ack
					if (beat_done)
					begin
						wb_cyc <= 1'b0;
						if (beat_last)
							state <= ifetch_pkg::fill_finish;
					end
					else if (!wb_cyc)
						wb_cyc <= 1'b1;
				end
				ifetch_pkg::fill_finish:
					state <= ifetch_pkg::fill_idle;
				default:
					state <= ifetch_pkg::fill_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (miss_en)
			pending_addr[miss_thread] <= miss_addr;
		if (start)
			fill_line <= (pending_addr[pick] >> LINE_SHIFT) << LINE_SHIFT;
	end

endmodule

/* hdl/ifetch_unit.sv */
////////////////////////////////////////
// Fetch front end top level
// Two pipeline stages, fill machine, WB port
////////////////////////////////////////

`timescale 1ns/1ps

module ifetch_unit(
	input  logic                       clk,
	input  logic                       reset,
	input  ifetch_pkg::thread_bitmap_t fetch_en,
	output logic                       instr_valid,
	output ifetch_pkg::scalar_t        instr,
	output ifetch_pkg::scalar_t        instr_pc,
	output ifetch_pkg::thread_idx_t    instr_thread,
	output logic                       wb_cyc,
	output logic                       wb_stb,
	output ifetch_pkg::scalar_t        wb_adr,
	input  ifetch_pkg::scalar_t        wb_rdata,
	input  logic                       wb_ack);

	logic fetch_valid;
	ifetch_pkg::scalar_t fetch_pc;
	ifetch_pkg::thread_idx_t fetch_thread;
	ifetch_pkg::l1i_tag_t line_tag;
	logic line_valid;

	// Miss report and wake pulse
	logic miss_en;
	ifetch_pkg::thread_idx_t miss_thread;
	ifetch_pkg::scalar_t miss_addr;
	ifetch_pkg::thread_bitmap_t wake_bitmap;

	l1i_fill_if fill_bus();

	ifetch_tag_stage tag_stage(
		.clk(clk), .reset(reset), .fetch_en(fetch_en), .fill(fill_bus.cache),
		.miss_en(miss_en), .miss_thread(miss_thread), .wake_bitmap(wake_bitmap),
		.fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .fetch_thread(fetch_thread),
		.line_tag(line_tag), .line_valid(line_valid));

	ifetch_data_stage data_stage(
		.clk(clk), .reset(reset), .fill(fill_bus.cache),
		.fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .fetch_thread(fetch_thread),
		.line_tag(line_tag), .line_valid(line_valid),
		.instr_valid(instr_valid), .instr(instr), .instr_pc(instr_pc),
		.instr_thread(instr_thread),
		.miss_en(miss_en), .miss_thread(miss_thread), .miss_addr(miss_addr));

	l1i_fill_fsm fill_fsm(
		.clk(clk), .reset(reset),
		.miss_en(miss_en), .miss_thread(miss_thread), .miss_addr(miss_addr),
		.fill(fill_bus.fsm), .wake_bitmap(wake_bitmap),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
		.wb_rdata(wb_rdata), .wb_ack(wb_ack));

endmodule

/* test/wb_instr_rom.sv */
////////////////////////////////////////
// Wishbone classic read-only memory model
// Each word reads as its address ^ 32'h5a5a0000,
// ack comes after a random wait of 0 to 3 cycles
////////////////////////////////////////

`timescale 1ns/1ps

module wb_instr_rom(
	input  logic                clk,
	input  logic                reset,
	input  logic                cyc,
	input  logic                stb,
	input  ifetch_pkg::scalar_t adr,
	output ifetch_pkg::scalar_t rdata,
	output logic                ack);

	// Request seen and wait already drawn
	logic busy;
	logic [1:0] wait_left;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			wait_left <= '0;
			ack <= 1'b0;
			rdata <= '0;
		end
		else if (ack)
		begin
			// Single-cycle ack, then wait for the next request
			ack <= 1'b0;
			busy <= 1'b0;
		end
		else if (cyc && stb)
		begin
			if (!busy)
			begin
				busy <= 1'b1;
				wait_left <= 2'($urandom % 4);
			end
			else if (wait_left == 2'd0)
			begin
				ack <= 1'b1;
				rdata <= adr ^ 32'h5a5a0000;
			end
			else
				wait_left <= wait_left - 1'b1;
		end
	end

endmodule

/* test/ifetch_unit_tb.sv */
////////////////////////////////////////
// Testbench of the fetch front end
// Drives fetch_en, serves fills from the ROM model,
// checks stream and bus with concurrent assertions
////////////////////////////////////////

`timescale 1ns/1ps
`include "ifetch_settings.svh"

module ifetch_unit_tb;

	localparam int PHASES = 4;
	localparam int PHASE_CYCLES = 4000;
	localparam int WAIT_LIMIT = 1000;
	localparam ifetch_pkg::scalar_t INSTR_MASK = 32'h5a5a0000;

	logic clk;
	logic reset;
	ifetch_pkg::thread_bitmap_t fetch_en;
	logic instr_valid;
	ifetch_pkg::scalar_t instr;
	ifetch_pkg::scalar_t instr_pc;
	ifetch_pkg::thread_idx_t instr_thread;
	logic wb_cyc;
	logic wb_stb;
	ifetch_pkg::scalar_t wb_adr;
	ifetch_pkg::scalar_t wb_rdata;
	logic wb_ack;

	int mismatch_count = 0;
	int failure_count = 0;

	// Scoreboard state
	ifetch_pkg::scalar_t expected_pc[`IFETCH_THREADS];
	int instr_count[`IFETCH_THREADS];
	ifetch_pkg::scalar_t pc_now;
	ifetch_pkg::thread_bitmap_t en_d1;
	ifetch_pkg::thread_bitmap_t en_d2;

	// Bus tracking state
	logic cyc_d;
	logic cyc_rise;
	logic [1:0] beat_expect;
	logic [27:0] line_expect;
	ifetch_pkg::scalar_t bus_expect_adr;
	ifetch_pkg::l1i_tag_t resident_tag[`L1I_SETS];
	logic [`L1I_SETS-1:0] resident_valid;
	logic line_resident;
	int fills_done;

	ifetch_unit dut(
		.clk(clk), .reset(reset), .fetch_en(fetch_en),
		.instr_valid(instr_valid), .instr(instr), .instr_pc(instr_pc),
		.instr_thread(instr_thread),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
		.wb_rdata(wb_rdata), .wb_ack(wb_ack));

	wb_instr_rom rom(
		.clk(clk), .reset(reset), .cyc(wb_cyc), .stb(wb_stb),
		.adr(wb_adr), .rdata(wb_rdata), .ack(wb_ack));

	always #2 clk = ~clk;

	task automatic count_mismatch(input string test, input ifetch_pkg::scalar_t expected,
		input ifetch_pkg::scalar_t actual);
		mismatch_count++;
		$display("mismatch %s: expected %h, actual %h", test, expected, actual);
	endtask

	task automatic note_failure(input string what);
		failure_count++;
		$display("error: %s at %0t", what, $time);
	endtask

	task automatic show_error_counts();
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
	endtask

	// Thread -1 accepts an instruction from any thread
	task automatic wait_for_thread(input string test, input int thread, input int count);
		int seen;
		int cycles;
		seen = 0;
		cycles = 0;
		while (seen < count && cycles < WAIT_LIMIT)
		begin
			@(negedge clk);
			cycles++;
			if (instr_valid && (thread < 0 || int'(instr_thread) == thread))
				seen++;
		end
		if (seen < count)
			note_failure($sformatf("%s: thread %0d delivered only %0d instructions", test,
				thread, seen));
	endtask

	task automatic wait_bus_idle();
		int quiet;
		int cycles;
		quiet = 0;
		cycles = 0;
		while (quiet < 8 && cycles < WAIT_LIMIT)
		begin
			@(negedge clk);
			cycles++;
			quiet = wb_cyc ? 0 : quiet + 1;
		end
		if (quiet < 8)
			note_failure("bus never went idle after fetch was disabled");
	endtask

	// Next expected program counter of every thread
	assign pc_now = expected_pc[instr_thread];

	always @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int t = 0; t < `IFETCH_THREADS; t++)
			begin
				expected_pc[t] <= `RESET_PC + t * `THREAD_PC_STRIDE;
				instr_count[t] <= 0;
			end
			en_d1 <= '0;
			en_d2 <= '0;
		end
		else
		begin
			// fetch_en as seen two edges before the output
			en_d1 <= fetch_en;
			en_d2 <= en_d1;
			if (instr_valid)
			begin
				expected_pc[instr_thread] <= expected_pc[instr_thread] + 32'd4;
				instr_count[instr_thread] <= instr_count[instr_thread] + 1;
			end
		end
	end

	// A fill is four single-word reads in word order within one aligned line
	assign cyc_rise = wb_cyc && !cyc_d;
	assign bus_expect_adr = (beat_expect == 2'd0) ? {wb_adr[31:4], 4'h0}
		: {line_expect, beat_expect, 2'b00};
	assign line_resident = resident_valid[wb_adr[7:4]]
		&& resident_tag[wb_adr[7:4]] == wb_adr[31:8];

	always @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			cyc_d <= 1'b0;
			beat_expect <= '0;
			line_expect <= '0;
			resident_valid <= '0;
			fills_done <= 0;
		end
		else
		begin
			cyc_d <= wb_cyc;
			if (wb_cyc && wb_ack)
			begin
				beat_expect <= beat_expect + 1'b1;
				// First beat evicts the old line of that set
				if (beat_expect == 2'd0)
				begin
					line_expect <= wb_adr[31:4];
					resident_valid[wb_adr[7:4]] <= 1'b0;
				end
				if (beat_expect == 2'(`L1I_LINE_WORDS - 1))
				begin
					resident_valid[wb_adr[7:4]] <= 1'b1;
					resident_tag[wb_adr[7:4]] <= wb_adr[31:8];
					fills_done <= fills_done + 1;
				end
			end
		end
	end

	a_reset_hold: assert property (@(posedge clk)
		reset |-> !instr_valid && !wb_cyc && !wb_stb)
		else note_failure("outputs active during reset");
	a_reset_exit: assert property (@(posedge clk)
		$fell(reset) |=> !instr_valid && !wb_cyc && !wb_stb)
		else note_failure("outputs active in the first cycle after reset");
	a_first_fill: assert property (@(posedge clk) disable iff (reset)
		instr_valid |-> fills_done > 0)
		else note_failure("instruction delivered before any line fill");
	a_contents: assert property (@(posedge clk) disable iff (reset)
		instr_valid |-> instr == (instr_pc ^ INSTR_MASK))
		else count_mismatch("instr_contents", $sampled(instr_pc) ^ INSTR_MASK, $sampled(instr));
	a_order: assert property (@(posedge clk) disable iff (reset)
		instr_valid |-> instr_pc == pc_now)
		else count_mismatch("program_order", $sampled(pc_now), $sampled(instr_pc));
	a_enable: assert property (@(posedge clk) disable iff (reset)
		instr_valid |-> en_d2[instr_thread])
		else note_failure("instruction from a thread whose fetch_en was low");
	a_stb_cyc: assert property (@(posedge clk) disable iff (reset) wb_stb |-> wb_cyc)
		else note_failure("wb_stb high without wb_cyc");
	a_hold: assert property (@(posedge clk) disable iff (reset)
		wb_cyc && !wb_ack |=> wb_cyc && wb_stb && $stable(wb_adr))
		else note_failure("bus request dropped or address changed before ack");
	a_drop: assert property (@(posedge clk) disable iff (reset) wb_cyc && wb_ack |=> !wb_cyc)
		else note_failure("wb_cyc still high in the cycle after ack");
	a_bus_adr: assert property (@(posedge clk) disable iff (reset)
		cyc_rise |-> wb_adr == bus_expect_adr)
		else count_mismatch("bus_address", $sampled(bus_expect_adr), $sampled(wb_adr));
	a_refill: assert property (@(posedge clk) disable iff (reset)
		cyc_rise && beat_expect == 2'd0 |-> !line_resident)
		else note_failure("line fetched again while still resident");

	initial
	begin
		void'($urandom(32'h7ab1103a));
		clk = 1'b0;
		reset = 1'b1;
		fetch_en = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Cold cache so every thread misses first
		fetch_en = '1;
		wait_for_thread("first_fill", -1, 1);

		// One thread at a time across several lines
		for (int t = 0; t < `IFETCH_THREADS; t++)
		begin
			fetch_en = ifetch_pkg::thread_bitmap_t'(1) << t;
			wait_for_thread("single_thread", t, 12);
		end

		// Random enable masks held for 20 to 59 cycles
		repeat (30)
		begin
			fetch_en = ifetch_pkg::thread_bitmap_t'($urandom);
			repeat (20 + $urandom % 40) @(negedge clk);
		end

		fetch_en = '0;
		wait_bus_idle();
		for (int t = 0; t < `IFETCH_THREADS; t++)
			if (instr_count[t] == 0)
				note_failure($sformatf("thread %0d never delivered an instruction", t));

		show_error_counts();
		if (mismatch_count == 0 && failure_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// Watchdog sized for all test phases
	initial
	begin
		repeat (PHASES * PHASE_CYCLES) @(posedge clk);
		note_failure("watchdog expired before the tests finished");
		show_error_counts();
		$display("Simulation FAILED");
		$finish;
	end

endmodule

/* project.f */
+incdir+hdl
hdl/ifetch_pkg.sv
hdl/l1i_fill_if.sv
hdl/fill_beat_counter.sv
hdl/ifetch_tag_stage.sv
hdl/ifetch_data_stage.sv
hdl/l1i_fill_fsm.sv
hdl/ifetch_unit.sv
test/wb_instr_rom.sv
test/ifetch_unit_tb.sv

/* Bender.yml */
package:
  name: ifetch_unit

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ifetch_pkg.sv
      - hdl/l1i_fill_if.sv
      - hdl/fill_beat_counter.sv
      - hdl/ifetch_tag_stage.sv
      - hdl/ifetch_data_stage.sv
      - hdl/l1i_fill_fsm.sv
      - hdl/ifetch_unit.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/wb_instr_rom.sv
      - test/ifetch_unit_tb.sv
